// File: logic/wb_bridge_pkg.sv
// ========================================
// Shared widths and types for the 16-bit
// Wishbone cross-clock subsystem.
// Addresses are word addresses (bits 19:1)
// and there is no byte address bit 0.
// ========================================

package wb_bridge_pkg;

  // word address, covers byte address bits 19 down to 1
  localparam int ADR_W = 19;

  // data bus width
  localparam int DAT_W = 16;

  // one select per byte lane
  localparam int SEL_W = 2;

  // width of one byte lane
  localparam int BYTE_W = DAT_W / SEL_W;

  // one classic single cycle, 39 bits
  // field order fixed, testbench builds these directly
  typedef struct packed {
    // word address
    logic [ADR_W-1:0] adr;
    // write data, ignored on reads
    logic [DAT_W-1:0] dat;
    // byte lane enables
    logic [SEL_W-1:0] sel;
    // space tag, high selects the I/O bank
    logic             tga;
    // write enable
    logic             we;
  } wb_req_t;

  // read data word on both clock domains
  typedef logic [DAT_W-1:0] wb_word_t;

endpackage

// File: logic/wb_regslice.sv
// ========================================
// Register slice on the processor clock.
// Master must hold stb, cyc and request
// until it sees ack; ack is one clock.
// Adds one cycle each way.
// ========================================

`timescale 1ns/1ps

module wb_regslice (
  input  logic                    rst_i,
  input  logic                    wbs_clk_i,

  // processor side
  input  wb_bridge_pkg::wb_req_t  wbs_req_i,
  input  logic                    wbs_stb_i,
  input  logic                    wbs_cyc_i,
  output wb_bridge_pkg::wb_word_t wbs_dat_o,
  output logic                    wbs_ack_o,

  // bridge side
  output wb_bridge_pkg::wb_req_t  req_reg_o,
  output logic                    stb_reg_o,
  input  wb_bridge_pkg::wb_word_t dat_reg_i,
  input  logic                    ack_reg_i
);

  import wb_bridge_pkg::*;

  // qualified strobe from the processor
  logic     stb_in;

  // registered strobe toward the bridge
  logic     stb_q;

  // registered ack toward the processor
  logic     ack_q;

  // request copy, follows the master while stb is up
  wb_req_t  req_q;

  // read data copy, loaded on the bridge ack
  wb_word_t dat_q;

  // cyc and stb only count together
  assign stb_in = wbs_stb_i & wbs_cyc_i;

  // control path
  always_ff @(posedge wbs_clk_i) begin
    if (rst_i) begin
      stb_q <= 1'b0;
      ack_q <= 1'b0;
    end else begin
      // drop strobe on the bridge ack and for the cycle after,
      // while the master still sees its ack and holds stb
      stb_q <= stb_in & ~ack_reg_i & ~ack_q;
      // single pulse in, single pulse out
      ack_q <= ack_reg_i;
    end
  end

  // payload path
  always_ff @(posedge wbs_clk_i) begin
    // hold last request once stb drops
    if (stb_in) begin
      req_q <= wbs_req_i;
    end
    // data lines up with ack_q
    if (ack_reg_i) begin
      dat_q <= dat_reg_i;
    end
  end

  // toward the bridge
  assign req_reg_o = req_q;
  assign stb_reg_o = stb_q;

  // toward the processor
  assign wbs_dat_o = dat_q;
  assign wbs_ack_o = ack_q;

endmodule

// File: logic/wb_abrg_reg.sv
// ========================================
// Wishbone clock-crossing bridge.
// One outstanding cycle only; toggle flag
// plus 3-stage synchronizer each way.
// Request must stay stable until ack.
// No error, retry or burst cycles.
// ========================================

`timescale 1ns/1ps

module wb_abrg_reg (
  input  logic                    rst_i,
  input  logic                    wbs_clk_i,
  input  logic                    wbm_clk_i,

  // processor domain, from the register slice
  input  wb_bridge_pkg::wb_req_t  wbs_req_i,
  input  logic                    wbs_stb_i,
  output wb_bridge_pkg::wb_word_t wbs_dat_o,
  output logic                    wbs_ack_o,

  // peripheral domain, toward the target
  output wb_bridge_pkg::wb_req_t  wbm_req_o,
  output logic                    wbm_stb_o,
  input  wb_bridge_pkg::wb_word_t wbm_dat_i,
  input  logic                    wbm_ack_i
);

  import wb_bridge_pkg::*;

  // processor domain state
  logic       stb_r;
  logic       ack_r;
  logic       init_tr;
  logic       ft_stb;
  logic       ack_pulse;
  logic [2:0] sync_ack;

  // peripheral domain state
  logic       wbm_stb;
  logic       ft_ack;
  logic [2:0] sync_stb;

  // request fields, two wbm stages
  wb_req_t    req_meta;
  wb_req_t    req_sync;

  // read data held from the target ack
  wb_word_t   rdat_wbm;

  // read data, two wbs stages
  wb_word_t   rdat_meta;
  wb_word_t   rdat_sync;

  // level change of the ack flag gives a one-clock pulse
  assign ack_pulse = sync_ack[2] ^ sync_ack[1];

  // new cycle on a rising strobe,
  // or on a strobe still high after the ack
  assign init_tr = (~stb_r & wbs_stb_i) | (ack_r & ~ack_pulse & wbs_stb_i);

  // start flag and edge history, processor clock
  always_ff @(posedge wbs_clk_i) begin
    if (rst_i) begin
      stb_r  <= 1'b0;
      ack_r  <= 1'b0;
      ft_stb <= 1'b0;
    end else begin
      stb_r <= wbs_stb_i;
      ack_r <= ack_pulse;
      if (init_tr) begin
        ft_stb <= ~ft_stb;
      end
    end
  end

  // ack flag back into the processor domain
  always_ff @(posedge wbs_clk_i) begin
    if (rst_i) begin
      sync_ack <= 3'b000;
    end else begin
      sync_ack <= {sync_ack[1:0], ft_ack};
    end
  end

  // start flag into the peripheral domain, local strobe, ack flag
  always_ff @(posedge wbm_clk_i) begin
    if (rst_i) begin
      sync_stb <= 3'b000;
      ft_ack   <= 1'b0;
      wbm_stb  <= 1'b0;
    end else begin
      sync_stb <= {sync_stb[1:0], ft_stb};
      // flips once per target ack
      if (wbm_ack_i) begin
        ft_ack <= ~ft_ack;
      end
      // set by the synced edge, held until the target acks
      if (wbm_stb) begin
        wbm_stb <= ~wbm_ack_i;
      end else begin
        wbm_stb <= sync_stb[2] ^ sync_stb[1];
      end
    end
  end

  // request fields settle well before the 3-stage strobe lands
  always_ff @(posedge wbm_clk_i) begin
    req_meta <= wbs_req_i;
    req_sync <= req_meta;
  end

  // target may change its data after ack, so keep a copy
  always_ff @(posedge wbm_clk_i) begin
    if (wbm_ack_i) begin
      rdat_wbm <= wbm_dat_i;
    end
  end

  // held copy is static by the time ack_pulse fires
  always_ff @(posedge wbs_clk_i) begin
    rdat_meta <= rdat_wbm;
    rdat_sync <= rdat_meta;
  end

  assign wbm_req_o = req_sync;
  assign wbm_stb_o = wbm_stb;
  assign wbs_dat_o = rdat_sync;
  assign wbs_ack_o = ack_pulse;

endmodule

// File: logic/wb_io_mem_target.sv
// ========================================
// Peripheral target: word memory when tga
// is low, four I/O registers when high.
// Ack is WAIT_STATES+1 clocks after stb.
// Memory has no reset; I/O regs clear.
// ========================================

`timescale 1ns/1ps

module wb_io_mem_target #(
  parameter int WAIT_STATES = 2,
  parameter int MEM_AW      = 8
) (
  input  logic                    rst_i,
  input  logic                    wbm_clk_i,
  input  wb_bridge_pkg::wb_req_t  req_i,
  input  logic                    stb_i,
  output wb_bridge_pkg::wb_word_t dat_o,
  output logic                    ack_o
);

  import wb_bridge_pkg::*;

  // counter wide enough for WAIT_STATES, at least one bit
  localparam int CNT_W = (WAIT_STATES > 0) ? $clog2(WAIT_STATES + 1) : 1;

  logic [CNT_W-1:0] ws_cnt;
  logic             last_ws;
  logic             wr_mem;
  logic             wr_io;

  // storage for both spaces
  wb_word_t mem [2**MEM_AW];
  wb_word_t io_reg [4];

  // final wait state of an open cycle, access happens here
  assign last_ws = stb_i & ~ack_o & (ws_cnt == CNT_W'(WAIT_STATES));
  assign wr_mem  = last_ws & req_i.we & ~req_i.tga;
  assign wr_io   = last_ws & req_i.we & req_i.tga;

  // wait-state count and ack
  always_ff @(posedge wbm_clk_i) begin
    if (rst_i) begin
      ws_cnt <= '0;
      ack_o  <= 1'b0;
    end else begin
      ack_o <= last_ws;
      // restart once the cycle ends or stb is gone
      if (stb_i && !ack_o && !last_ws) begin
        ws_cnt <= ws_cnt + 1'b1;
      end else begin
        ws_cnt <= '0;
      end
    end
  end

  // word memory, byte lanes per sel
  always_ff @(posedge wbm_clk_i) begin
    if (wr_mem) begin
      for (int b = 0; b < SEL_W; b++) begin
        if (req_i.sel[b]) begin
          mem[req_i.adr[MEM_AW-1:0]][b*BYTE_W +: BYTE_W] <= req_i.dat[b*BYTE_W +: BYTE_W];
        end
      end
    end
  end

  // I/O bank, same byte rule
  always_ff @(posedge wbm_clk_i) begin
    if (rst_i) begin
      io_reg <= '{default: '0};
    end else if (wr_io) begin
      for (int b = 0; b < SEL_W; b++) begin
        if (req_i.sel[b]) begin
          io_reg[req_i.adr[1:0]][b*BYTE_W +: BYTE_W] <= req_i.dat[b*BYTE_W +: BYTE_W];
        end
      end
    end
  end

  // read data valid with ack; writes return the old word
  always_ff @(posedge wbm_clk_i) begin
    if (last_ws) begin
      dat_o <= req_i.tga ? io_reg[req_i.adr[1:0]] : mem[req_i.adr[MEM_AW-1:0]];
    end
  end

endmodule

// File: logic/wb_xclk_top.sv
// ========================================
// Cross-clock subsystem top level.
// wbs_clk_i and wbm_clk_i may be unrelated.
// Single cycles only, one at a time.
// MEM_AW must not exceed the 19-bit adr.
// ========================================

`timescale 1ns/1ps

module wb_xclk_top #(
  parameter int WAIT_STATES = 2,
  parameter int MEM_AW      = 8
) (
  input  logic                    rst_i,
  input  logic                    wbs_clk_i,
  input  logic                    wbm_clk_i,

  // processor port
  input  wb_bridge_pkg::wb_req_t  wbs_req_i,
  input  logic                    wbs_stb_i,
  input  logic                    wbs_cyc_i,
  output wb_bridge_pkg::wb_word_t wbs_dat_o,
  output logic                    wbs_ack_o
);

  import wb_bridge_pkg::*;

  // slice to bridge
  wb_req_t  slc_req;
  logic     slc_stb;
  wb_word_t brg_dat;
  logic     brg_ack;

  // bridge to target
  wb_req_t  tgt_req;
  logic     tgt_stb;
  wb_word_t tgt_dat;
  logic     tgt_ack;

  // timing break on the processor clock
  wb_regslice wb_regslice_i (
    .rst_i     (rst_i),
    .wbs_clk_i (wbs_clk_i),
    .wbs_req_i (wbs_req_i),
    .wbs_stb_i (wbs_stb_i),
    .wbs_cyc_i (wbs_cyc_i),
    .wbs_dat_o (wbs_dat_o),
    .wbs_ack_o (wbs_ack_o),
    .req_reg_o (slc_req),
    .stb_reg_o (slc_stb),
    .dat_reg_i (brg_dat),
    .ack_reg_i (brg_ack)
  );

  // domain crossing
  wb_abrg_reg wb_abrg_reg_i (
    .rst_i     (rst_i),
    .wbs_clk_i (wbs_clk_i),
    .wbm_clk_i (wbm_clk_i),
    .wbs_req_i (slc_req),
    .wbs_stb_i (slc_stb),
    .wbs_dat_o (brg_dat),
    .wbs_ack_o (brg_ack),
    .wbm_req_o (tgt_req),
    .wbm_stb_o (tgt_stb),
    .wbm_dat_i (tgt_dat),
    .wbm_ack_i (tgt_ack)
  );

  // cyc equals stb on this side, target only sees stb
  wb_io_mem_target #(
    .WAIT_STATES (WAIT_STATES),
    .MEM_AW      (MEM_AW)
  ) wb_io_mem_target_i (
    .rst_i     (rst_i),
    .wbm_clk_i (wbm_clk_i),
    .req_i     (tgt_req),
    .stb_i     (tgt_stb),
    .dat_o     (tgt_dat),
    .ack_o     (tgt_ack)
  );

endmodule

// File: verif/wb_clk_gen.sv
// ========================================
// Free-running simulation clock.
// Starts low, first rise after half a
// period. Period given in ns.
// ========================================

`timescale 1ns/1ps

module wb_clk_gen #(
  parameter real PERIOD_NS = 8.0
) (
  output logic clk_o
);

  // one toggle per half period, forever
  initial begin
    clk_o = 1'b0;
    forever begin
      #(PERIOD_NS / 2.0);
      clk_o = ~clk_o;
    end
  end

endmodule

// File: verif/wb_xclk_asserts.sv
// ========================================
// Handshake checks on the bridge, bound
// into every wb_abrg_reg instance.
// fail_cnt totals the failed checks.
// ========================================

`timescale 1ns/1ps

module wb_xclk_asserts (
  input  logic                   rst_i,
  input  logic                   wbs_clk_i,
  input  logic                   wbm_clk_i,
  input  wb_bridge_pkg::wb_req_t wbm_req_o,
  input  logic                   wbm_stb_o,
  input  logic                   wbm_ack_i,
  input  logic                   wbs_ack_o
);

  // one counter per property
  int unsigned stb_errs = 0;
  int unsigned req_errs = 0;
  int unsigned ack_errs = 0;

  // total, read by the testbench
  int unsigned fail_cnt;

  assign fail_cnt = stb_errs + req_errs + ack_errs;

  // peripheral strobe ends on each target ack and at no other time
  stb_drop_on_ack: assert property (
    @(posedge wbm_clk_i) disable iff (rst_i)
    $fell(wbm_stb_o) == $past(wbm_ack_i)
  ) else begin
    stb_errs++;
    $error("wbm_stb_o did not fall exactly one clock after wbm_ack_i");
  end

  // request must not move under an open strobe
  req_hold_in_cycle: assert property (
    @(posedge wbm_clk_i) disable iff (rst_i)
    (wbm_stb_o && $past(wbm_stb_o)) |-> $stable(wbm_req_o)
  ) else begin
    req_errs++;
    $error("wbm_req_o changed while wbm_stb_o was high");
  end

  // processor-side ack is a single pulse
  ack_single_pulse: assert property (
    @(posedge wbs_clk_i) disable iff (rst_i)
    wbs_ack_o |=> !wbs_ack_o
  ) else begin
    ack_errs++;
    $error("wbs_ack_o high on two clocks in a row");
  end

endmodule

bind wb_abrg_reg wb_xclk_asserts wb_xclk_asserts_i (
  .rst_i     (rst_i),
  .wbs_clk_i (wbs_clk_i),
  .wbm_clk_i (wbm_clk_i),
  .wbm_req_o (wbm_req_o),
  .wbm_stb_o (wbm_stb_o),
  .wbm_ack_i (wbm_ack_i),
  .wbs_ack_o (wbs_ack_o)
);

// File: verif/wb_xclk_tb.sv
// ========================================
// Testbench for the cross-clock subsystem.
// Vectors come from the golden hex file,
// path relative to the project root.
// Read data is checked on reads only.
// ========================================

`timescale 1ns/1ps

module wb_xclk_tb;

  import wb_bridge_pkg::*;

  localparam int WAIT_STATES = 2;
  localparam int MEM_AW      = 8;
  localparam int WBM_PERIOD  = 8;
  localparam int WBS_PERIOD  = 10;

  // golden file layout
  localparam int NUM_VEC = 26;
  localparam int FIELDS  = 6;

  // wbm part of the latency, in wbs cycles rounded up
  localparam int WBM_PART = ((4 + WAIT_STATES + 1) * WBM_PERIOD + WBS_PERIOD - 1) / WBS_PERIOD;
  // per-cycle ack bound, twice the expected latency
  localparam int ACK_WAIT = 2 * (4 + 2 + WBM_PART);
  // whole-run bound in wbs cycles
  localparam int RUN_LIMIT = NUM_VEC * 40;

  logic     wbm_clk_i;
  logic     wbs_clk_i;
  logic     rst_i;
  wb_req_t  wbs_req_i;
  logic     wbs_stb_i;
  logic     wbs_cyc_i;
  wb_word_t wbs_dat_o;
  logic     wbs_ack_o;

  // one token per entry, six per vector
  logic [23:0] gold [NUM_VEC*FIELDS];

  int err_cnt;
  int chk_cnt;
  int cycle_cnt;

  wb_clk_gen #(.PERIOD_NS(WBM_PERIOD)) wbm_clk_gen_i (.clk_o(wbm_clk_i));
  wb_clk_gen #(.PERIOD_NS(WBS_PERIOD)) wbs_clk_gen_i (.clk_o(wbs_clk_i));

  wb_xclk_top #(
    .WAIT_STATES (WAIT_STATES),
    .MEM_AW      (MEM_AW)
  ) wb_xclk_top_i (
    .rst_i     (rst_i),
    .wbs_clk_i (wbs_clk_i),
    .wbm_clk_i (wbm_clk_i),
    .wbs_req_i (wbs_req_i),
    .wbs_stb_i (wbs_stb_i),
    .wbs_cyc_i (wbs_cyc_i),
    .wbs_dat_o (wbs_dat_o),
    .wbs_ack_o (wbs_ack_o)
  );

  // read word against golden value
  task automatic check_word(input int vec, input wb_word_t exp, input wb_word_t act);
    chk_cnt++;
    if (act !== exp) begin
      err_cnt++;
      $display("mismatch wbs_dat_o vec %0d expected 0x%04h actual 0x%04h", vec, exp, act);
    end
  endtask

  // ack seen against ack wanted
  task automatic check_ack(input int vec, input logic exp, input logic act);
    chk_cnt++;
    if (act !== exp) begin
      err_cnt++;
      if (exp) begin
        $display("vec %0d: no ack on wbs_ack_o within %0d wbs cycles", vec, ACK_WAIT);
      end else begin
        $display("vec %0d: extra ack on wbs_ack_o while no cycle was open", vec);
      end
    end
  endtask

  // one classic cycle, called on a falling edge
  task automatic run_cycle(input wb_req_t req, output logic got_ack, output wb_word_t rdat);
    int waited;
    waited  = 0;
    got_ack = 1'b0;
    rdat    = '0;
    wbs_req_i <= req;
    wbs_stb_i <= 1'b1;
    wbs_cyc_i <= 1'b1;
    while (!got_ack && waited < ACK_WAIT) begin
      @(negedge wbs_clk_i);
      waited++;
      // ack and data both settle after the rising edge
      if (wbs_ack_o === 1'b1) begin
        got_ack = 1'b1;
        rdat    = wbs_dat_o;
      end
    end
    // stb drops on the same edge the ack was seen
    wbs_stb_i <= 1'b0;
    wbs_cyc_i <= 1'b0;
  endtask

  // idle clocks, no ack allowed
  task automatic idle_gap(input int vec, input int n);
    repeat (n) begin
      @(negedge wbs_clk_i);
      check_ack(vec, 1'b0, wbs_ack_o);
    end
  endtask

  // whole-run watchdog
  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < RUN_LIMIT) begin
      @(posedge wbs_clk_i);
      cycle_cnt++;
    end
    $display("timeout: run did not end within %0d wbs cycles", RUN_LIMIT);
    $display("Testbench failed");
    $finish;
  end

  initial begin
    wb_req_t     req;
    logic        got_ack;
    wb_word_t    rdat;
    wb_word_t    exp;
    int          base;
    int          gap;
    int          err_before;
    int unsigned asrt_errs;
    string       status;
    void'($urandom(32'h6247));
    err_cnt   = 0;
    chk_cnt   = 0;
    rst_i     = 1'b1;
    wbs_req_i = '0;
    wbs_stb_i = 1'b0;
    wbs_cyc_i = 1'b0;
    $readmemh("verif/wb_xclk_golden.hex", gold);

    // reset spans both domains
    repeat (16) @(posedge wbm_clk_i);
    @(negedge wbs_clk_i);
    rst_i <= 1'b0;
    idle_gap(0, 2);

    for (int v = 0; v < NUM_VEC; v++) begin
      base       = v * FIELDS;
      err_before = err_cnt;
      req.we     = gold[base][0];
      req.tga    = gold[base+1][0];
      req.adr    = gold[base+2][ADR_W-1:0];
      req.sel    = gold[base+3][SEL_W-1:0];
      req.dat    = gold[base+4][DAT_W-1:0];
      exp        = gold[base+5][DAT_W-1:0];
      run_cycle(req, got_ack, rdat);
      check_ack(v, 1'b1, got_ack);
      // writes return the old word, not checked
      if (got_ack && !req.we) begin
        check_word(v, exp, rdat);
      end
      status = (err_cnt == err_before) ? "ok" : "FAIL";
      $display("vec %0d %s %s adr %05h sel %0h data %04h %s", v,
               req.we ? "write" : "read", req.tga ? "io" : "mem",
               req.adr, req.sel, req.we ? req.dat : rdat, status);
      // random idle between cycles, 1 to 5 clocks
      gap = 1 + int'($urandom % 5);
      idle_gap(v, gap);
    end

    asrt_errs = wb_xclk_top_i.wb_abrg_reg_i.wb_xclk_asserts_i.fail_cnt;
    $display("vectors %0d checks %0d errors %0d assertion failures %0d",
             NUM_VEC, chk_cnt, err_cnt, asrt_errs);
    if (err_cnt == 0 && asrt_errs == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// File: verif/wb_xclk_golden.hex
// columns: we tga adr sel wdat rdat, all hex, one cycle per line
// rdat is the expected read word; on writes it is ignored
0 1 00000 3 0000 0000
0 1 00001 3 0000 0000
0 1 00002 3 0000 0000
0 1 00003 3 0000 0000
1 0 00010 3 a5c3 0000
1 0 000ff 3 1234 0000
1 0 00000 3 beef 0000
1 0 7ff45 3 c0de 0000
0 0 00010 3 0000 a5c3
0 0 000ff 3 0000 1234
0 0 00000 3 0000 beef
0 0 00045 3 0000 c0de
1 0 00010 1 5577 0000
1 0 000ff 2 99aa 0000
0 0 00010 3 0000 a577
0 0 000ff 3 0000 9934
1 1 00001 3 0f0f 0000
1 0 00001 3 7e81 0000
0 1 00001 3 0000 0f0f
0 0 00001 3 0000 7e81
1 1 00002 2 5a3c 0000
1 1 00002 1 ff11 0000
0 1 00002 3 0000 5a11
0 1 00003 3 0000 0000
0 0 00010 3 0000 a577
0 1 00005 3 0000 0f0f

// File: list.f
logic/wb_bridge_pkg.sv
logic/wb_regslice.sv
logic/wb_abrg_reg.sv
logic/wb_io_mem_target.sv
logic/wb_xclk_top.sv
verif/wb_clk_gen.sv
verif/wb_xclk_asserts.sv
verif/wb_xclk_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the cross-clock testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module wb_xclk_tb -f list.f -o wb_xclk_sim

# output goes to the terminal; status comes from the search
./obj_dir/wb_xclk_sim +verilator+error+limit+100 | tee /dev/stderr \
  | grep -x "Testbench passed" > /dev/null
